// ==== clb_fabric_top.f ====
rtl/clb_pkg.sv
rtl/clb_logic.sv
rtl/clb_config_chain.sv
rtl/clb_row.sv
rtl/clb_fabric_top.sv
verif/clb_clock_gen.sv
verif/clb_fabric_tb.sv

// ==== verif/clb_fabric_tb.sv ====
`timescale 1ns/10ps

module clb_fabric_tb;

   localparam int NUM_CLB     = 4;
   localparam int CFG_CREDITS = 2;
   localparam int RUN_CYCLES  = 200;
   localparam int NUM_PHASES  = 8;
   localparam int PHASE_SETUP = 50;  // Reset plus loading with room for gaps
   localparam int TIMEOUT_CYCLES = 2 * NUM_PHASES * (RUN_CYCLES + PHASE_SETUP);
   localparam int LOAD_LIMIT  = CFG_CREDITS + 4;
   localparam int K_MIXED     = 0;
   localparam int K_LUT4      = 1;
   localparam int K_LUT3X2    = 2;
   localparam int K_BSEL      = 3;
   localparam int K_STORE_K   = 4;
   localparam int K_STORE_C   = 5;
   localparam int K_STORE_G   = 6;

   logic KLK;
   logic gen_rst_n;
   logic phase_rst_n;
   logic rst_n;
   clb_pkg::cfg_link_t cfg_in;
   logic cfg_credit;
   logic cfg_done;
   logic [NUM_CLB-1:0] a_pins;
   logic [NUM_CLB-1:0] b_pins;
   logic [NUM_CLB-1:0] d_pins;
   logic c0_pin;
   logic k_pin;
   logic [NUM_CLB-1:0] x_pins;
   logic [NUM_CLB-1:0] y_pins;

   // Reference model state
   clb_pkg::clb_cfg_t m_fifo [$];
   clb_pkg::clb_cfg_t m_words [NUM_CLB];
   clb_pkg::clb_cfg_t tx_words [NUM_CLB+1];
   logic [NUM_CLB-1:0] m_q;
   logic [NUM_CLB-1:0] m_smp;
   logic [NUM_CLB-1:0] m_edge;
   logic [NUM_CLB-1:0] m_clk;
   logic [NUM_CLB-1:0] m_qn;
   logic [NUM_CLB-1:0] m_x;
   logic [NUM_CLB-1:0] m_y;
   logic [NUM_CLB-1:0] x_prev;
   logic m_done = 1'b0;
   logic m_ran = 1'b0;
   logic exp_credit = 1'b0;
   logic credit_smp = 1'b0;
   logic in_reset = 1'b0;
   logic model_live = 1'b0;
   int m_pops = 0;
   int credits = CFG_CREDITS;
   int cycle_cnt = 0;
   int value_errors = 0;
   int proto_errors = 0;
   int other_errors = 0;
   logic [31:0] lfsr_state = 32'h5008;

   assign rst_n = gen_rst_n & phase_rst_n;

   clb_clock_gen u_clk_gen (
      .KLK   (KLK),
      .rst_n (gen_rst_n)
   );

   clb_fabric_top #(
      .NUM_CLB     (NUM_CLB),
      .CFG_CREDITS (CFG_CREDITS)
   ) dut (
      .KLK        (KLK),
      .rst_n      (rst_n),
      .cfg_in     (cfg_in),
      .cfg_credit (cfg_credit),
      .cfg_done   (cfg_done),
      .a_pins     (a_pins),
      .b_pins     (b_pins),
      .d_pins     (d_pins),
      .c0_pin     (c0_pin),
      .k_pin      (k_pin),
      .x_pins     (x_pins),
      .y_pins     (y_pins)
   );

   // ------------------------------------------------------------
   // Random source from a Fibonacci LFSR with taps 32 22 2 1
   // ------------------------------------------------------------
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int j = 0; j < n; j++)
      begin
         lfsr_state = {lfsr_state[30:0],
                       lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
         v = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic logic [1:0] rand_sel3();
      logic [1:0] v;
      v = 2'(rand_bits(2));
      return (v == 2'd3) ? 2'd2 : v;
   endfunction

   function automatic clb_pkg::clb_cfg_t make_word(input int kind);
      clb_pkg::clb_cfg_t w;
      w.lut.lut4  = 16'(rand_bits(16));
      w.comb_mode = clb_pkg::comb_mode_e'(rand_sel3());
      w.f_in_sel  = 3'(rand_bits(3));
      w.g_in_sel  = 3'(rand_bits(3));
      w.dq1_sel   = 1'(rand_bits(1));
      w.dq2_sel   = 1'(rand_bits(1));
      w.s_sel     = clb_pkg::src3_e'(rand_sel3());
      w.r_sel     = clb_pkg::src3_e'(rand_sel3());
      w.clk_sel   = clb_pkg::src3_e'(rand_sel3());
      w.x_sel     = clb_pkg::src3_e'(rand_sel3());
      w.y_sel     = clb_pkg::src3_e'(rand_sel3());
      case (kind)
         K_LUT4:
         begin
            w.comb_mode = clb_pkg::COMB_LUT4;
            w.x_sel     = clb_pkg::SEL_0;   // X shows F
         end
         K_LUT3X2:
         begin
            w.comb_mode = clb_pkg::COMB_LUT3X2;
            w.y_sel     = clb_pkg::SEL_1;   // Y shows G
         end
         K_BSEL:    w.comb_mode = clb_pkg::COMB_BSEL;
         K_STORE_K: w.clk_sel   = clb_pkg::SEL_2;
         K_STORE_C: w.clk_sel   = clb_pkg::SEL_1;
         K_STORE_G: w.clk_sel   = clb_pkg::SEL_0;
      endcase
      if (kind >= K_STORE_K)
      begin
         w.x_sel = clb_pkg::SEL_2;          // Q seen through X
      end
      return w;
   endfunction

   // ------------------------------------------------------------
   // Behavioral model that walks the C chain from block 0 up
   // ------------------------------------------------------------
   task automatic eval_model();
      clb_pkg::clb_cfg_t w;
      logic [15:0] t;
      logic a;
      logic b;
      logic c;
      logic d;
      logic dq1;
      logic dq2;
      logic f;
      logic g;
      logic s;
      logic r;
      for (int i = 0; i < NUM_CLB; i++)
      begin
         w   = m_words[i];
         t   = w.lut.lut4;
         a   = a_pins[i];
         b   = b_pins[i];
         d   = d_pins[i];
         if (i == 0)
            c = c0_pin;
         else
            c = m_x[i-1];
         dq1 = w.dq1_sel ? m_q[i] : d;
         dq2 = w.dq2_sel ? m_q[i] : d;
         case (w.comb_mode)
            clb_pkg::COMB_LUT3X2:
            begin
               f = t[{1'b0, w.f_in_sel[2] ? b : a, w.f_in_sel[1] ? c : b,
                      w.f_in_sel[0] ? dq1 : c}];
               g = t[{1'b1, w.g_in_sel[2] ? b : a, w.g_in_sel[1] ? c : b,
                      w.g_in_sel[0] ? dq2 : c}];
            end
            clb_pkg::COMB_BSEL:
            begin
               f = b ? t[{1'b1, a, c, dq2}] : t[{1'b0, a, c, dq1}];
               g = f;
            end
            default:
            begin
               f = t[{a, b, c, dq1}];
               g = f;
            end
         endcase
         s = (w.s_sel == clb_pkg::SEL_0) ? a : (w.s_sel == clb_pkg::SEL_1) ? f : 1'b0;
         r = (w.r_sel == clb_pkg::SEL_0) ? d : (w.r_sel == clb_pkg::SEL_1) ? g : 1'b0;
         m_clk[i] = (w.clk_sel == clb_pkg::SEL_0) ? g :
                    (w.clk_sel == clb_pkg::SEL_1) ? c : k_pin;
         m_x[i] = (w.x_sel == clb_pkg::SEL_0) ? f : (w.x_sel == clb_pkg::SEL_1) ? g : m_q[i];
         m_y[i] = (w.y_sel == clb_pkg::SEL_0) ? m_q[i] : (w.y_sel == clb_pkg::SEL_1) ? g : f;
         m_qn[i] = r ? 1'b0 : (s ? 1'b1 : f);  // Reset, then set, then F
      end
   endtask

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
      value_errors++;
      $display("Fail at %0t: %s expected %0h, got %0h", $time, name, exp, got);
   endtask

   task automatic print_counts();
      $display("Errors: value %0d, protocol %0d, other %0d",
               value_errors, proto_errors, other_errors);
   endtask

   // Model step and source checks on every rising edge
   always @(posedge KLK)
   begin : model_step
      logic push;
      logic pop;
      eval_model();
      if (!rst_n)
      begin
         m_fifo.delete();
         for (int i = 0; i < NUM_CLB; i++)
            m_words[i] = '0;
         m_q        = '0;
         m_smp      = '0;
         m_edge     = '0;
         m_pops     = 0;
         m_done     = 1'b0;
         m_ran      = 1'b0;
         exp_credit = 1'b0;
         credits    = CFG_CREDITS;
         in_reset   = 1'b1;
         model_live = 1'b1;
      end
      else
      begin
         assert (!(cfg_in.valid && m_fifo.size() >= CFG_CREDITS))
         else
         begin
            proto_errors++;
            $display("Error: word sent into a full buffer");
         end
         in_reset = 1'b0;
         m_ran    = m_done;
         m_edge   = '0;
         if (m_done)
         begin
            m_edge = m_clk & ~m_smp;
            m_q    = (m_edge & m_qn) | (~m_edge & m_q);
            m_smp  = m_clk;
         end
         push = cfg_in.valid && (m_fifo.size() < CFG_CREDITS);
         pop  = (m_fifo.size() > 0) && !m_done;
         if (pop)
         begin
            for (int i = 0; i < NUM_CLB - 1; i++)
               m_words[i] = m_words[i+1];
            m_words[NUM_CLB-1] = m_fifo.pop_front();
            m_pops++;
         end
         if (push)
            m_fifo.push_back(cfg_in.word);
         credits = credits - int'(cfg_in.valid) + int'(credit_smp);
         assert (credits <= CFG_CREDITS)
         else
         begin
            proto_errors++;
            $display("Error: more credits than words sent");
         end
         m_done     = (m_pops == NUM_CLB);
         exp_credit = pop;
      end
   end

   // Compares in the middle of each cycle
   always @(negedge KLK)
   begin
      credit_smp = cfg_credit;
      if (model_live)
      begin
         eval_model();
         assert (cfg_credit === exp_credit)
            else report_value("cfg_credit", exp_credit, cfg_credit);
         assert (cfg_done === m_done)
            else report_value("cfg_done", m_done, cfg_done);
         assert (x_pins === m_x)
            else report_value("x_pins", m_x, x_pins);
         assert (y_pins === m_y)
            else report_value("y_pins", m_y, y_pins);
         if (in_reset)
         begin
            assert (!cfg_credit && !cfg_done && x_pins == '0 && y_pins == '0)
            else
            begin
               other_errors++;
               $display("Error: outputs not cleared by reset");
            end
         end
         if (m_ran && !in_reset)
         begin
            for (int i = 0; i < NUM_CLB; i++)
            begin
               if (m_words[i].x_sel == clb_pkg::SEL_2 && !m_edge[i])
               begin
                  assert (x_pins[i] === x_prev[i])
                  else
                  begin
                     other_errors++;
                     $display("Error: block %0d stored bit moved without an edge", i);
                  end
               end
            end
         end
         x_prev = x_pins;
      end
   end

   always @(posedge KLK)
   begin
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: tests still running after %0d cycles", cycle_cnt);
         print_counts();
         $display("FAIL: see errors above");
         $finish;
      end
   end

   // ------------------------------------------------------------
   // Stimulus
   // ------------------------------------------------------------
   task automatic apply_reset();
      @(posedge KLK);
      #1;
      phase_rst_n  = 1'b0;
      cfg_in.valid = 1'b0;
      repeat (5) @(posedge KLK);
      #1;
      phase_rst_n = 1'b1;
   endtask

   task automatic send_words(input bit gaps, input int first, input int last);
      int n;
      n = first;
      while (n < last)
      begin
         @(posedge KLK);
         #1;
         if (credits > 0 && !(gaps && rand_bits(1)))
         begin
            cfg_in.valid = 1'b1;
            cfg_in.word  = tx_words[n];
            n++;
         end
         else
            cfg_in.valid = 1'b0;
      end
      @(posedge KLK);
      #1;
      cfg_in.valid = 1'b0;
   endtask

   task automatic wait_done();
      int waited;
      waited = 0;
      while (cfg_done !== 1'b1 && waited < LOAD_LIMIT)
      begin
         @(posedge KLK);
         #1;
         waited++;
      end
      if (cfg_done !== 1'b1)
      begin
         other_errors++;
         $display("Error: cfg_done still low %0d cycles after the last word", LOAD_LIMIT);
      end
   endtask

   task automatic run_random(input int cycles);
      repeat (cycles)
      begin
         @(posedge KLK);
         #1;
         a_pins = NUM_CLB'(rand_bits(NUM_CLB));
         b_pins = NUM_CLB'(rand_bits(NUM_CLB));
         d_pins = NUM_CLB'(rand_bits(NUM_CLB));
         c0_pin = 1'(rand_bits(1));
         k_pin  = 1'(rand_bits(1));
      end
   endtask

   task automatic run_phase(input int kind, input bit gaps, input bit extra);
      apply_reset();
      for (int i = 0; i <= NUM_CLB; i++)
         tx_words[i] = make_word(kind);
      send_words(gaps, 0, NUM_CLB);
      wait_done();
      if (extra)
         send_words(1'b0, NUM_CLB, NUM_CLB + 1);  // Late word that is never popped
      run_random(RUN_CYCLES);
   endtask

   initial
   begin
      cfg_in      = '0;
      a_pins      = '0;
      b_pins      = '0;
      d_pins      = '0;
      c0_pin      = 1'b0;
      k_pin       = 1'b0;
      phase_rst_n = 1'b1;
      wait (gen_rst_n === 1'b1);
      run_phase(K_MIXED, 1'b0, 1'b1);
      run_phase(K_MIXED, 1'b1, 1'b1);
      run_phase(K_LUT4, 1'b0, 1'b0);
      run_phase(K_LUT3X2, 1'b1, 1'b0);
      run_phase(K_BSEL, 1'b0, 1'b0);
      run_phase(K_STORE_K, 1'b1, 1'b0);
      run_phase(K_STORE_C, 1'b0, 1'b0);
      run_phase(K_STORE_G, 1'b1, 1'b0);
      print_counts();
      if (value_errors + proto_errors + other_errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

// ==== verif/clb_clock_gen.sv ====
`timescale 1ns/10ps

module clb_clock_gen #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 5
) (
   output logic KLK,
   output logic rst_n
);

   initial
   begin
      KLK = 1'b0;
      forever #(HALF_PERIOD) KLK = ~KLK;
   end

   // Release lands just after an edge as the stimulus does
   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge KLK);
      #1;
      rst_n = 1'b1;
   end

endmodule

// ==== rtl/clb_fabric_top.sv ====
`timescale 1ns/10ps

module clb_fabric_top #(
   parameter int NUM_CLB     = 4,
   parameter int CFG_CREDITS = 2
) (
   input  logic               KLK,
   input  logic               rst_n,
   input  clb_pkg::cfg_link_t cfg_in,
   output logic               cfg_credit,
   output logic               cfg_done,
   input  logic [NUM_CLB-1:0] a_pins,
   input  logic [NUM_CLB-1:0] b_pins,
   input  logic [NUM_CLB-1:0] d_pins,
   input  logic               c0_pin,
   input  logic               k_pin,
   output logic [NUM_CLB-1:0] x_pins,
   output logic [NUM_CLB-1:0] y_pins
);

   clb_pkg::clb_cfg_t [NUM_CLB-1:0] cfg_words;

   // Configuration intake
   clb_config_chain #(
      .NUM_CLB     (NUM_CLB),
      .CFG_CREDITS (CFG_CREDITS)
   ) u_cfg_chain (
      .KLK        (KLK),
      .rst_n      (rst_n),
      .cfg_in     (cfg_in),
      .cfg_credit (cfg_credit),
      .cfg_words  (cfg_words),
      .cfg_done   (cfg_done)
   );

   // Logic row runs once every block holds its word
   clb_row #(
      .NUM_CLB (NUM_CLB)
   ) u_row (
      .KLK       (KLK),
      .rst_n     (rst_n),
      .run       (cfg_done),
      .cfg_words (cfg_words),
      .a_pins    (a_pins),
      .b_pins    (b_pins),
      .d_pins    (d_pins),
      .c0_pin    (c0_pin),
      .k_pin     (k_pin),
      .x_pins    (x_pins),
      .y_pins    (y_pins)
   );

endmodule

// ==== rtl/clb_row.sv ====
`timescale 1ns/10ps

module clb_row #(
   parameter int NUM_CLB = 4
) (
   input  logic                            KLK,
   input  logic                            rst_n,
   input  logic                            run,
   input  clb_pkg::clb_cfg_t [NUM_CLB-1:0] cfg_words,
   input  logic [NUM_CLB-1:0]              a_pins,
   input  logic [NUM_CLB-1:0]              b_pins,
   input  logic [NUM_CLB-1:0]              d_pins,
   input  logic                            c0_pin,
   input  logic                            k_pin,
   output logic [NUM_CLB-1:0]              x_pins,
   output logic [NUM_CLB-1:0]              y_pins
);

   logic [NUM_CLB-1:0] c_chain;  // C input of each block

   // ------------------------------------------------------------
   // Blocks and fixed neighbor wiring
   // ------------------------------------------------------------
   for (genvar i = 0; i < NUM_CLB; i++)
   begin : g_clb
      if (i == 0)
      begin : g_head
         assign c_chain[i] = c0_pin;
      end
      else
      begin : g_link
         assign c_chain[i] = x_pins[i-1];  // X of the block below
      end

      clb_logic u_clb (
         .KLK   (KLK),
         .rst_n (rst_n),
         .run   (run),
         .cfg   (cfg_words[i]),
         .a     (a_pins[i]),
         .b     (b_pins[i]),
         .c     (c_chain[i]),
         .d     (d_pins[i]),
         .k     (k_pin),
         .x     (x_pins[i]),
         .y     (y_pins[i])
      );
   end

endmodule

// ==== rtl/clb_config_chain.sv ====
`timescale 1ns/10ps

module clb_config_chain #(
   parameter int NUM_CLB     = 4,
   parameter int CFG_CREDITS = 2
) (
   input  logic                              KLK,
   input  logic                              rst_n,
   input  clb_pkg::cfg_link_t                cfg_in,
   output logic                              cfg_credit,
   output clb_pkg::clb_cfg_t [NUM_CLB-1:0]   cfg_words,
   output logic                              cfg_done
);

   localparam int PTR_W = (CFG_CREDITS > 1) ? $clog2(CFG_CREDITS) : 1;
   localparam int LVL_W = $clog2(CFG_CREDITS + 1);
   localparam int POP_W = $clog2(NUM_CLB + 1);

   logic [clb_pkg::CFG_W-1:0] fifo_mem [CFG_CREDITS];
   logic [PTR_W-1:0]          wr_ptr;
   logic [PTR_W-1:0]          rd_ptr;
   logic [LVL_W-1:0]          fifo_lvl;
   logic [POP_W-1:0]          pop_cnt;
   logic                      push;
   logic                      pop;
   clb_pkg::clb_cfg_t         head;

   // ------------------------------------------------------------
   // Intake FIFO
   // ------------------------------------------------------------
   assign push = cfg_in.valid && (fifo_lvl != LVL_W'(CFG_CREDITS));  // Full drops the word
   assign pop  = (fifo_lvl != '0) && !cfg_done;
   assign head = fifo_mem[rd_ptr];

   always_ff @(posedge KLK)
   begin
      if (push)
      begin
         fifo_mem[wr_ptr] <= cfg_in.word;
      end
   end

   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         fifo_lvl <= '0;
      end
      else
      begin
         if (push)
         begin
            wr_ptr <= (wr_ptr == PTR_W'(CFG_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop)
         begin
            rd_ptr <= (rd_ptr == PTR_W'(CFG_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   fifo_lvl <= fifo_lvl + 1'b1;
            2'b01:   fifo_lvl <= fifo_lvl - 1'b1;
            default: fifo_lvl <= fifo_lvl;
         endcase
      end
   end

   // ------------------------------------------------------------
   // Shift chain and credit return
   // ------------------------------------------------------------
   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         cfg_words  <= '0;
         pop_cnt    <= '0;
         cfg_credit <= 1'b0;
      end
      else
      begin
         cfg_credit <= pop;  // One credit per pop one cycle later
         if (pop)
         begin
            for (int i = 0; i < NUM_CLB - 1; i++)
            begin
               cfg_words[i] <= cfg_words[i+1];
            end
            cfg_words[NUM_CLB-1] <= head;  // Newest word enters at the top
            pop_cnt              <= pop_cnt + 1'b1;
         end
      end
   end

   // Stays high until reset since pops stop here
   assign cfg_done = (pop_cnt == POP_W'(NUM_CLB));

endmodule

// ==== rtl/clb_logic.sv ====
`timescale 1ns/10ps

module clb_logic (
   input  logic              KLK,
   input  logic              rst_n,
   input  logic              run,
   input  clb_pkg::clb_cfg_t cfg,
   input  logic              a,
   input  logic              b,
   input  logic              c,
   input  logic              d,
   input  logic              k,
   output logic              x,
   output logic              y
);

   logic dq1;
   logic dq2;
   logic fa;
   logic fb;
   logic fc;
   logic ga;
   logic gb;
   logic gc;
   logic f;
   logic g;
   logic s;
   logic r;
   logic clk_src;
   logic clk_smp;    // Last sample of clk_src
   logic q;
   logic q_next;

   assign dq1 = cfg.dq1_sel ? q : d;
   assign dq2 = cfg.dq2_sel ? q : d;

   // Input selection for the split 3-input mode
   assign fa = cfg.f_in_sel[2] ? b : a;
   assign fb = cfg.f_in_sel[1] ? c : b;
   assign fc = cfg.f_in_sel[0] ? dq1 : c;
   assign ga = cfg.g_in_sel[2] ? b : a;
   assign gb = cfg.g_in_sel[1] ? c : b;
   assign gc = cfg.g_in_sel[0] ? dq2 : c;

   // ------------------------------------------------------------
   // Function generators
   // ------------------------------------------------------------
   always_comb
   begin
      case (cfg.comb_mode)
         clb_pkg::COMB_LUT3X2:
         begin
            f = cfg.lut.halves.lut_lo[{fa, fb, fc}];
            g = cfg.lut.halves.lut_hi[{ga, gb, gc}];
         end
         clb_pkg::COMB_BSEL:
         begin
            if (b)
            begin
               f = cfg.lut.halves.lut_hi[{a, c, dq2}];
            end
            else
            begin
               f = cfg.lut.halves.lut_lo[{a, c, dq1}];
            end
            g = f;  // Both outputs follow the chosen half
         end
         default:
         begin
            f = cfg.lut.lut4[{a, b, c, dq1}];
            g = f;
         end
      endcase
   end

   // ------------------------------------------------------------
   // Source selectors
   // ------------------------------------------------------------
   always_comb
   begin
      case (cfg.s_sel)
         clb_pkg::SEL_0: s = a;
         clb_pkg::SEL_1: s = f;
         default:        s = 1'b0;
      endcase
      case (cfg.r_sel)
         clb_pkg::SEL_0: r = d;
         clb_pkg::SEL_1: r = g;
         default:        r = 1'b0;
      endcase
      case (cfg.clk_sel)
         clb_pkg::SEL_0: clk_src = g;
         clb_pkg::SEL_1: clk_src = c;
         default:        clk_src = k;
      endcase
      case (cfg.x_sel)
         clb_pkg::SEL_0: x = f;
         clb_pkg::SEL_1: x = g;
         default:        x = q;
      endcase
      case (cfg.y_sel)
         clb_pkg::SEL_0: y = q;
         clb_pkg::SEL_1: y = g;
         default:        y = f;
      endcase
   end

   // Reset wins over set
   assign q_next = r ? 1'b0 : (s ? 1'b1 : f);

   // Storage bit clocked on a sampled rising edge of clk_src
   always_ff @(posedge KLK)
   begin
      if (!rst_n)
      begin
         clk_smp <= 1'b0;
         q       <= 1'b0;
      end
      else if (run)
      begin
         clk_smp <= clk_src;
         if (clk_src && !clk_smp)
         begin
            q <= q_next;
         end
      end
   end

endmodule

// ==== rtl/clb_pkg.sv ====
package clb_pkg;

   // ------------------------------------------------------------
   // Function generator modes
   // ------------------------------------------------------------
   typedef enum logic [1:0]
   {
      COMB_LUT4   = 2'b00,  // One 4-input function with F equal to G
      COMB_LUT3X2 = 2'b01,  // Two independent 3-input functions
      COMB_BSEL   = 2'b10   // B picks the table half
   } comb_mode_e;

   // Three-way selector whose meaning depends on the mux it drives
   typedef enum logic [1:0]
   {
      SEL_0 = 2'b00,
      SEL_1 = 2'b01,
      SEL_2 = 2'b10
   } src3_e;

   // ------------------------------------------------------------
   // Lookup table as one word seen two ways
   // ------------------------------------------------------------
   typedef struct packed
   {
      logic [7:0] lut_hi;  // Entries 8..15, G side
      logic [7:0] lut_lo;  // Entries 0..7, F side
   } lut_halves_t;

   typedef union packed
   {
      logic [15:0] lut4;   // Indexed by {A,B,C,DQ1}
      lut_halves_t halves;
   } lut_table_u;

   // ------------------------------------------------------------
   // Per-block configuration word
   // ------------------------------------------------------------
   typedef struct packed
   {
      lut_table_u lut;
      comb_mode_e comb_mode;
      logic [2:0] f_in_sel;  // Bit 2 A/B, bit 1 B/C, bit 0 C/DQ1
      logic [2:0] g_in_sel;  // Bit 2 A/B, bit 1 B/C, bit 0 C/DQ2
      logic       dq1_sel;   // 0 takes D, 1 takes Q
      logic       dq2_sel;
      src3_e      s_sel;     // A, F, 0
      src3_e      r_sel;     // D, G, 0
      src3_e      clk_sel;   // G, C, K
      src3_e      x_sel;     // F, G, Q
      src3_e      y_sel;     // Q, G, F
   } clb_cfg_t;

   localparam int CFG_W = $bits(clb_cfg_t);

   // Word on the configuration port
   typedef struct packed
   {
      logic     valid;
      clb_cfg_t word;
   } cfg_link_t;

endpackage
